/* compile.f */
+incdir+hw
hw/aluPkg.sv
hw/aluSimpleOps.sv
hw/intDivider.sv
hw/intSqrt.sv
hw/aluControl.sv
hw/alu.sv
dv/alu_checker.sv
dv/aluTb.sv

/* dv/aluTb.sv */
`include "alu_config.svh"

module aluTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ClockPeriod = 8;
    localparam int ResetCycles = 4;
    localparam int DriveDelay  = 1;
    localparam int WaitLimit   = 40;  // Cycles allowed per operation
    localparam int MaxOps      = 400;
    localparam int RandomPairs = 40;
    localparam int WatchdogNs  = MaxOps * WaitLimit * ClockPeriod;

    logic                  Clock;
    logic                  i_reset;
    logic [`ALU_WIDTH-1:0] i_operandA;
    logic [`ALU_WIDTH-1:0] i_operandB;
    logic [5:0]            i_opcode;
    logic                  i_start;
    logic                  o_done;
    logic [`ALU_WIDTH-1:0] o_result;

    int          checkCount;
    int          mismatchCount;
    int          timeoutCount;
    logic [31:0] lcgState;

    alu UUT (
        .Clock      (Clock),
        .i_reset    (i_reset),
        .i_operandA (i_operandA),
        .i_operandB (i_operandB),
        .i_opcode   (i_opcode),
        .i_start    (i_start),
        .o_done     (o_done),
        .o_result   (o_result)
    );

    always #(ClockPeriod / 2) Clock = ~Clock;

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [`ALU_WIDTH-1:0] simpleModel(input logic [5:0] op,
            input logic [`ALU_WIDTH-1:0] a, input logic [`ALU_WIDTH-1:0] b);
        logic [`ALU_WIDTH-1:0] r;
        r = '0;  // Unused codes give zero
        case (op)
            aluPkg::IntAdd:     r = a + b;
            aluPkg::IntSub:     r = a - b;
            aluPkg::IntMul:     r = a * b;
            aluPkg::ShiftLeft:  r = a << b[4:0];
            aluPkg::ShiftRight: r = a >> b[4:0];
            aluPkg::CmpEq:      r = (a == b) ? 1 : 0;
            aluPkg::CmpNe:      r = (a != b) ? 1 : 0;
            aluPkg::CmpGt:      r = (a > b) ? 1 : 0;
            aluPkg::CmpGe:      r = (a >= b) ? 1 : 0;
            aluPkg::CmpLt:      r = (a < b) ? 1 : 0;
            aluPkg::CmpLe:      r = (a <= b) ? 1 : 0;
            aluPkg::BitNot:     r = ~a;
            aluPkg::BitAnd:     r = a & b;
            aluPkg::BitOr:      r = a | b;
            aluPkg::BitXor:     r = a ^ b;
            aluPkg::BitXnor:    r = ~(a ^ b);
            default:            r = '0;
        endcase
        return r;
    endfunction

    function automatic logic [`ALU_WIDTH-1:0] divModel(input logic [5:0] op,
            input logic [`ALU_WIDTH-1:0] a, input logic [`ALU_WIDTH-1:0] b);
        logic                  isSigned;
        logic                  wantRem;
        logic [`ALU_WIDTH-1:0] q;
        logic [`ALU_WIDTH-1:0] r;
        isSigned = (op == aluPkg::IntDiv) || (op == aluPkg::IntRem);
        wantRem  = (op == aluPkg::IntRem) || (op == aluPkg::IntRemU);
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (isSigned && a == {1'b1, {(`ALU_WIDTH-1){1'b0}}} && b == '1) begin
            q = a;  // Overflow case
            r = '0;
        end else if (isSigned) begin
            q = $signed(a) / $signed(b);  // Truncates, remainder keeps dividend sign
            r = $signed(a) % $signed(b);
        end else begin
            q = a / b;
            r = a % b;
        end
        return wantRem ? r : q;
    endfunction

    // Floor root by binary search
    function automatic logic [`ALU_WIDTH-1:0] sqrtModel(input logic [`ALU_WIDTH-1:0] x);
        longint unsigned lo;
        longint unsigned hi;
        longint unsigned mid;
        lo = 0;
        hi = (64'd1 << `SQRT_STEPS) - 1;
        while (lo < hi) begin
            mid = (lo + hi + 1) / 2;
            if (mid * mid <= x) begin
                lo = mid;
            end else begin
                hi = mid - 1;
            end
        end
        return `ALU_WIDTH'(lo);
    endfunction

    function automatic logic [`ALU_WIDTH-1:0] expectedResult(input logic [5:0] op,
            input logic [`ALU_WIDTH-1:0] a, input logic [`ALU_WIDTH-1:0] b);
        if (op == aluPkg::IntDiv || op == aluPkg::IntRem
                || op == aluPkg::IntDivU || op == aluPkg::IntRemU) begin
            return divModel(op, a, b);
        end else if (op == aluPkg::IntSqrt) begin
            return sqrtModel(a);
        end
        return simpleModel(op, a, b);
    endfunction

    task automatic checkValue(input string name, input logic [`ALU_WIDTH-1:0] expected,
            input logic [`ALU_WIDTH-1:0] actual);
        checkCount++;
        if (actual !== expected) begin
            $display("Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
            mismatchCount++;
        end
    endtask

    // Called 1 ns after an edge with o_done high
    task automatic runOp(input logic [5:0] op, input logic [`ALU_WIDTH-1:0] a,
            input logic [`ALU_WIDTH-1:0] b, output int edges);
        logic [`ALU_WIDTH-1:0] expected;
        expected   = expectedResult(op, a, b);
        i_opcode   = op;
        i_operandA = a;
        i_operandB = b;
        i_start    = 1'b1;
        @(posedge Clock);
        #DriveDelay;
        i_start = 1'b0;
        edges   = 1;
        checkValue("o_done", 0, o_done);
        while (!o_done && edges < WaitLimit) begin
            @(posedge Clock);
            #DriveDelay;
            edges++;
        end
        if (!o_done) begin
            $display("Opcode %0d did not finish within %0d cycles at %0d ns",
                     op, WaitLimit, $time);
            timeoutCount++;
        end else begin
            checkValue("o_result", expected, o_result);
        end
    endtask

    task automatic testReset();
        checkValue("o_done", 1, o_done);
        checkValue("o_result", 0, o_result);
    endtask

    task automatic testSimpleOps();
        logic [5:0] opList [16] = '{aluPkg::IntAdd, aluPkg::IntSub, aluPkg::IntMul,
            aluPkg::ShiftLeft, aluPkg::ShiftRight, aluPkg::CmpEq, aluPkg::CmpNe,
            aluPkg::CmpGt, aluPkg::CmpGe, aluPkg::CmpLt, aluPkg::CmpLe, aluPkg::BitNot,
            aluPkg::BitAnd, aluPkg::BitOr, aluPkg::BitXor, aluPkg::BitXnor};
        logic [`ALU_WIDTH-1:0] a;
        logic [`ALU_WIDTH-1:0] b;
        int edges;
        foreach (opList[i]) begin
            for (int n = 0; n < RandomPairs; n++) begin
                a = lcgNext();
                b = (n % 4 == 0) ? a : lcgNext();  // Equal pairs for the compares
                runOp(opList[i], a, b, edges);
                if (edges != 2) begin
                    $display("Simple opcode %0d took %0d edges instead of 2", opList[i], edges);
                    timeoutCount++;
                end
            end
        end
    endtask

    task automatic testDivide();
        logic [5:0] divOps [4] = '{aluPkg::IntDiv, aluPkg::IntRem,
            aluPkg::IntDivU, aluPkg::IntRemU};
        logic [`ALU_WIDTH-1:0] dirA [8] = '{32'hFFFFFF9C, 32'd100, 32'hFFFFFF9C, 32'd7,
            32'hFFFFFFFB, 32'h80000000, 32'h80000000, 32'hFFFFFFFF};
        logic [`ALU_WIDTH-1:0] dirB [8] = '{32'd7, 32'hFFFFFFF9, 32'hFFFFFFF9, 32'd0,
            32'd0, 32'hFFFFFFFF, 32'd1, 32'd1};
        logic [`ALU_WIDTH-1:0] a;
        logic [`ALU_WIDTH-1:0] b;
        int edges;
        foreach (divOps[i]) begin
            foreach (dirA[k]) begin
                runOp(divOps[i], dirA[k], dirB[k], edges);
            end
            for (int n = 0; n < 30; n++) begin
                a = lcgNext();
                b = lcgNext() >> (lcgNext() >> 27);  // Spread divisor sizes
                runOp(divOps[i], a, b, edges);
            end
        end
    endtask

    task automatic testSqrt();
        logic [`ALU_WIDTH-1:0] values [11] = '{32'd0, 32'd1, 32'd4, 32'd15, 32'd16, 32'd17,
            32'd152399025, 32'hFFFE0001, 32'hFFFFFFFF, 32'h40000000, 32'd99};
        int edges;
        foreach (values[k]) begin
            runOp(aluPkg::IntSqrt, values[k], '0, edges);
        end
        for (int n = 0; n < 16; n++) begin
            runOp(aluPkg::IntSqrt, lcgNext(), '0, edges);
        end
    endtask

    task automatic testIgnoredStart();
        logic [`ALU_WIDTH-1:0] expected;
        int cycles;
        expected   = divModel(aluPkg::IntDiv, 32'd1000003, 32'hFFFFFFF9);
        i_opcode   = aluPkg::IntDiv;
        i_operandA = 32'd1000003;
        i_operandB = 32'hFFFFFFF9;
        i_start    = 1'b1;
        @(posedge Clock);
        #DriveDelay;
        i_start = 1'b0;
        repeat (5) @(posedge Clock);
        #DriveDelay;
        // Start while busy, must be dropped
        i_opcode   = aluPkg::IntAdd;
        i_operandA = 32'd1;
        i_operandB = 32'd2;
        i_start    = 1'b1;
        @(posedge Clock);
        #DriveDelay;
        i_start = 1'b0;
        checkValue("o_done", 0, o_done);
        cycles = 0;
        while (!o_done && cycles < WaitLimit) begin
            @(posedge Clock);
            #DriveDelay;
            cycles++;
        end
        if (!o_done) begin
            $display("Divide with an ignored start never finished");
            timeoutCount++;
        end
        checkValue("o_result", expected, o_result);
        repeat (6) begin
            @(posedge Clock);
            #DriveDelay;
            checkValue("o_done", 1, o_done);
            checkValue("o_result", expected, o_result);
        end
    endtask

    task automatic testBackToBack();
        logic [5:0] seq [10] = '{aluPkg::IntAdd, aluPkg::IntDiv, aluPkg::IntSqrt,
            aluPkg::BitXor, aluPkg::IntRemU, aluPkg::CmpLt, 6'd13, aluPkg::IntRem,
            aluPkg::ShiftLeft, aluPkg::IntSqrt};
        int edges;
        for (int n = 0; n < 30; n++) begin
            runOp(seq[n % 10], lcgNext(), lcgNext() >> 8, edges);
        end
        runOp(6'd63, 32'hFFFFFFFF, 32'hFFFFFFFF, edges);
    endtask

    initial begin
        #WatchdogNs;
        $display("Watchdog expired after %0d ns, the tests did not finish", WatchdogNs);
        $display("Test failed");
        $finish;
    end

    initial begin
        Clock         = 1'b0;
        i_reset       = 1'b1;
        i_start       = 1'b0;
        i_opcode      = '0;
        i_operandA    = '0;
        i_operandB    = '0;
        checkCount    = 0;
        mismatchCount = 0;
        timeoutCount  = 0;
        lcgState      = 32'd83;
        repeat (ResetCycles) @(posedge Clock);
        #DriveDelay;
        i_reset = 1'b0;
        testReset();
        testSimpleOps();
        testDivide();
        testSqrt();
        testIgnoredStart();
        testBackToBack();
        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checkCount, mismatchCount, timeoutCount);
        if (mismatchCount == 0 && timeoutCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* dv/alu_checker.sv */
`include "alu_config.svh"

module aluChecker (
    input logic                  Clock,
    input logic                  i_reset,
    input logic                  i_start,
    input logic                  i_done,
    input logic [`ALU_WIDTH-1:0] i_result,
    input logic                  i_divCyc,
    input logic                  i_divStb,
    input logic                  i_divAck,
    input aluPkg::ctrlState      i_state
);
    timeunit 1ns;
    timeprecision 1ps;

    logic accepted;

    assign accepted = i_start && i_done;  // CPU side start rule

    startClearsDone: assert property (@(posedge Clock) disable iff (i_reset)
        accepted |=> !i_done)
        else $error("Accepted start left o_done high");

    resultHeld: assert property (@(posedge Clock) disable iff (i_reset)
        (i_done && !i_start) |=> $stable(i_result))
        else $error("o_result changed while done without a start");

    stbNeedsCyc: assert property (@(posedge Clock) disable iff (i_reset)
        (i_divStb || i_divAck) |-> i_divCyc)
        else $error("Divider strobe or ack outside a bus cycle");

    // Bus cycle held until the slave acks
    cycHeldToAck: assert property (@(posedge Clock) disable iff (i_reset)
        (i_divCyc && i_divStb && !i_divAck) |=> (i_divCyc && i_divStb))
        else $error("Divider cycle dropped before ack");

    startOnlyFromIdle: assert property (@(posedge Clock) disable iff (i_reset)
        accepted |-> (i_state == aluPkg::Idle))
        else $error("Start accepted while the FSM was not Idle");

endmodule

bind aluControl aluChecker controlChecks (
    .Clock       (Clock),
    .i_reset     (i_reset),
    .i_start     (i_start),
    .i_done      (o_done),
    .i_result    (o_result),
    .i_divCyc    (o_divCyc),
    .i_divStb    (o_divStb),
    .i_divAck    (i_divAck),
    .i_state     (state)
);

/* hw/alu.sv */
`include "alu_config.svh"

module alu (
    input  logic                   Clock,
    input  logic                   i_reset,
    input  logic [`ALU_WIDTH-1:0]  i_operandA,
    input  logic [`ALU_WIDTH-1:0]  i_operandB,
    input  logic [5:0]             i_opcode,
    input  logic                   i_start,
    output logic                   o_done,
    output logic [`ALU_WIDTH-1:0]  o_result
);

    aluPkg::aluOp               opcode;
    logic [`ALU_WIDTH-1:0]      opA;
    logic [`ALU_WIDTH-1:0]      opB;
    logic [`ALU_WIDTH-1:0]      simpleResult;

    // Divider bus
    logic                       divCyc;
    logic                       divStb;
    logic [2*`ALU_WIDTH-1:0]    divOperands;
    logic [1:0]                 divTag;
    logic                       divAck;
    logic [`ALU_WIDTH-1:0]      divResult;

    logic                       sqrtStart;
    logic [`ALU_WIDTH-1:0]      radicand;
    logic                       sqrtDone;
    logic [`ALU_WIDTH-1:0]      sqrtRoot;

    aluControl control (
        .Clock          (Clock),
        .i_reset        (i_reset),
        .i_operandA     (i_operandA),
        .i_operandB     (i_operandB),
        .i_opcode       (i_opcode),
        .i_start        (i_start),
        .i_simpleResult (simpleResult),
        .i_divAck       (divAck),
        .i_divResult    (divResult),
        .i_sqrtDone     (sqrtDone),
        .i_sqrtRoot     (sqrtRoot),
        .o_done         (o_done),
        .o_result       (o_result),
        .o_opcode       (opcode),
        .o_opA          (opA),
        .o_opB          (opB),
        .o_divCyc       (divCyc),
        .o_divStb       (divStb),
        .o_divOperands  (divOperands),
        .o_divTag       (divTag),
        .o_sqrtStart    (sqrtStart),
        .o_radicand     (radicand)
    );

    aluSimpleOps simpleOps (
        .i_opcode (opcode),
        .i_opA    (opA),
        .i_opB    (opB),
        .o_result (simpleResult)
    );

    intDivider divider (
        .Clock        (Clock),
        .i_reset      (i_reset),
        .i_wbCyc      (divCyc),
        .i_wbStb      (divStb),
        .i_wbOperands (divOperands),
        .i_wbTag      (divTag),
        .o_wbAck      (divAck),
        .o_wbData     (divResult)
    );

    intSqrt sqrtUnit (
        .Clock      (Clock),
        .i_reset    (i_reset),
        .i_start    (sqrtStart),
        .i_radicand (radicand),
        .o_done     (sqrtDone),
        .o_root     (sqrtRoot)
    );

endmodule

/* hw/aluControl.sv */
`include "alu_config.svh"

module aluControl (
    input  logic                      Clock,
    input  logic                      i_reset,
    input  logic [`ALU_WIDTH-1:0]     i_operandA,
    input  logic [`ALU_WIDTH-1:0]     i_operandB,
    input  logic [5:0]                i_opcode,
    input  logic                      i_start,
    input  logic [`ALU_WIDTH-1:0]     i_simpleResult,
    input  logic                      i_divAck,
    input  logic [`ALU_WIDTH-1:0]     i_divResult,
    input  logic                      i_sqrtDone,
    input  logic [`ALU_WIDTH-1:0]     i_sqrtRoot,
    output logic                      o_done,
    output logic [`ALU_WIDTH-1:0]     o_result,
    output aluPkg::aluOp              o_opcode,
    output logic [`ALU_WIDTH-1:0]     o_opA,
    output logic [`ALU_WIDTH-1:0]     o_opB,
    output logic                      o_divCyc,
    output logic                      o_divStb,
    output logic [2*`ALU_WIDTH-1:0]   o_divOperands,
    output logic [1:0]                o_divTag,
    output logic                      o_sqrtStart,
    output logic [`ALU_WIDTH-1:0]     o_radicand
);

    aluPkg::ctrlState state;
    aluPkg::aluOp     newOp;
    logic             accept;
    logic             isDivOp;
    logic             isSqrtOp;

    assign newOp  = aluPkg::aluOp'(i_opcode);
    assign accept = i_start & o_done & (state == aluPkg::Idle);

    always_comb begin
        isDivOp  = 1'b0;
        isSqrtOp = 1'b0;
        case (newOp)
            aluPkg::IntDiv, aluPkg::IntRem, aluPkg::IntDivU, aluPkg::IntRemU: begin
                isDivOp = 1'b1;
            end
            aluPkg::IntSqrt: begin
                isSqrtOp = 1'b1;
            end
            default: begin
                isDivOp  = 1'b0;
                isSqrtOp = 1'b0;
            end
        endcase
    end

    // Operands stay put for the whole bus cycle
    assign o_divOperands = {o_opA, o_opB};
    assign o_divTag[0]   = (o_opcode == aluPkg::IntRem) || (o_opcode == aluPkg::IntRemU);
    assign o_divTag[1]   = (o_opcode == aluPkg::IntDiv) || (o_opcode == aluPkg::IntRem);
    assign o_radicand    = o_opA;

    always_ff @(posedge Clock) begin
        if (accept) begin
            o_opcode <= newOp;
            o_opA    <= i_operandA;
            o_opB    <= i_operandB;
        end
    end

    always_ff @(posedge Clock) begin
        if (i_reset) begin
            state       <= aluPkg::Idle;
            o_done      <= 1'b1;
            o_result    <= '0;
            o_divCyc    <= 1'b0;
            o_divStb    <= 1'b0;
            o_sqrtStart <= 1'b0;
        end else begin
            o_sqrtStart <= 1'b0;
            case (state)
                aluPkg::Idle: begin
                    if (!o_done) begin
                        o_result <= i_simpleResult;  // Simple op pending
                        o_done   <= 1'b1;
                    end else if (accept) begin
                        o_done <= 1'b0;
                        if (isDivOp) begin
                            state    <= aluPkg::DivWait;
                            o_divCyc <= 1'b1;
                            o_divStb <= 1'b1;
                        end else if (isSqrtOp) begin
                            state       <= aluPkg::SqrtWait;
                            o_sqrtStart <= 1'b1;
                        end
                    end
                end
                aluPkg::DivWait: begin
                    if (i_divAck) begin
                        o_divCyc <= 1'b0;  // Close the cycle after ack
                        o_divStb <= 1'b0;
                        o_result <= i_divResult;
                        o_done   <= 1'b1;
                        state    <= aluPkg::Idle;
                    end
                end
                aluPkg::SqrtWait: begin
                    if (i_sqrtDone) begin
                        o_result <= i_sqrtRoot;
                        o_done   <= 1'b1;
                        state    <= aluPkg::Idle;
                    end
                end
                default: begin
                    state <= aluPkg::Idle;
                end
            endcase
        end
    end

endmodule

/* hw/aluPkg.sv */
package aluPkg;

    // Operation codes, float codes of the old map are unused
    typedef enum logic [5:0] {
        // Integer arithmetic
        IntAdd     = 6'd0,
        IntSub     = 6'd1,
        IntMul     = 6'd2,
        IntSqrt    = 6'd3,
        IntDiv     = 6'd4,
        IntRem     = 6'd5,
        // Shifts
        ShiftLeft  = 6'd6,
        ShiftRight = 6'd7,
        // Unsigned divider variants
        IntDivU    = 6'd8,
        IntRemU    = 6'd9,
        // Unsigned compares, result 0 or 1
        CmpEq      = 6'd16,
        CmpNe      = 6'd17,
        CmpGt      = 6'd18,
        CmpGe      = 6'd19,
        CmpLt      = 6'd20,
        CmpLe      = 6'd21,
        // Bitwise
        BitNot     = 6'd24,
        BitAnd     = 6'd25,
        BitOr      = 6'd26,
        BitXor     = 6'd27,
        BitXnor    = 6'd28
    } aluOp;

    // Control FSM
    typedef enum logic [1:0] {
        Idle,
        DivWait,  // Divider bus cycle open
        SqrtWait  // Root engine running
    } ctrlState;

endpackage

/* hw/aluSimpleOps.sv */
`include "alu_config.svh"

module aluSimpleOps (
    input  aluPkg::aluOp           i_opcode,
    input  logic [`ALU_WIDTH-1:0]  i_opA,
    input  logic [`ALU_WIDTH-1:0]  i_opB,
    output logic [`ALU_WIDTH-1:0]  o_result
);

    logic [$clog2(`ALU_WIDTH)-1:0] shiftAmount;

    assign shiftAmount = i_opB[$clog2(`ALU_WIDTH)-1:0];  // Low bits of B only

    always_comb begin
        o_result = '0;
        case (i_opcode)
            aluPkg::IntAdd: begin
                o_result = i_opA + i_opB;
            end
            aluPkg::IntSub: begin
                o_result = i_opA - i_opB;
            end
            aluPkg::IntMul: begin
                o_result = i_opA * i_opB;  // Low word, same for signed
            end
            aluPkg::ShiftLeft: begin
                o_result = i_opA << shiftAmount;
            end
            aluPkg::ShiftRight: begin
                o_result = i_opA >> shiftAmount;  // Logical
            end
            aluPkg::CmpEq: begin
                o_result = `ALU_WIDTH'(i_opA == i_opB);
            end
            aluPkg::CmpNe: begin
                o_result = `ALU_WIDTH'(i_opA != i_opB);
            end
            aluPkg::CmpGt: begin
                o_result = `ALU_WIDTH'(i_opA > i_opB);
            end
            aluPkg::CmpGe: begin
                o_result = `ALU_WIDTH'(i_opA >= i_opB);
            end
            aluPkg::CmpLt: begin
                o_result = `ALU_WIDTH'(i_opA < i_opB);
            end
            aluPkg::CmpLe: begin
                o_result = `ALU_WIDTH'(i_opA <= i_opB);
            end
            aluPkg::BitNot: begin
                o_result = ~i_opA;
            end
            aluPkg::BitAnd: begin
                o_result = i_opA & i_opB;
            end
            aluPkg::BitOr: begin
                o_result = i_opA | i_opB;
            end
            aluPkg::BitXor: begin
                o_result = i_opA ^ i_opB;
            end
            aluPkg::BitXnor: begin
                o_result = i_opA ~^ i_opB;
            end
            default: begin
                o_result = '0;  // Long ops and unused codes
            end
        endcase
    end

endmodule

/* hw/alu_config.svh */
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// Operand and result width
`define ALU_WIDTH 32

// One quotient bit per divider step
`define DIV_STEPS `ALU_WIDTH

// Two radicand bits per root step
`define SQRT_STEPS (`ALU_WIDTH / 2)

`endif

/* hw/intDivider.sv */
`include "alu_config.svh"

module intDivider (
    input  logic                      Clock,
    input  logic                      i_reset,
    input  logic                      i_wbCyc,
    input  logic                      i_wbStb,
    input  logic [2*`ALU_WIDTH-1:0]   i_wbOperands,  // {dividend, divisor}
    input  logic [1:0]                i_wbTag,       // {signed, remainder}
    output logic                      o_wbAck,
    output logic [`ALU_WIDTH-1:0]     o_wbData
);

    logic [`ALU_WIDTH-1:0] dividendIn;
    logic [`ALU_WIDTH-1:0] divisorIn;
    logic                  negDividend;
    logic                  negDivisor;
    logic [`ALU_WIDTH-1:0] absDividend;
    logic [`ALU_WIDTH-1:0] absDivisor;
    logic                  divByZero;
    logic                  overflow;
    logic                  start;

    logic                  busy;
    logic [$clog2(`DIV_STEPS):0] stepCount;
    logic                  lastStep;

    logic [`ALU_WIDTH-1:0] remReg;
    logic [`ALU_WIDTH-1:0] quoReg;
    logic [`ALU_WIDTH-1:0] divisorReg;
    logic                  negQuo;
    logic                  negRem;
    logic                  remSel;

    logic [`ALU_WIDTH-1:0] stepRem;
    logic [`ALU_WIDTH-1:0] stepQuo;
    logic [`ALU_WIDTH-1:0] stepDiv;
    logic [`ALU_WIDTH:0]   trial;
    logic                  fits;
    logic [`ALU_WIDTH-1:0] nextRem;
    logic [`ALU_WIDTH-1:0] nextQuo;
    logic [`ALU_WIDTH-1:0] finalRem;
    logic [`ALU_WIDTH-1:0] finalQuo;

    assign dividendIn  = i_wbOperands[2*`ALU_WIDTH-1:`ALU_WIDTH];
    assign divisorIn   = i_wbOperands[`ALU_WIDTH-1:0];
    assign negDividend = i_wbTag[1] & dividendIn[`ALU_WIDTH-1];
    assign negDivisor  = i_wbTag[1] & divisorIn[`ALU_WIDTH-1];
    assign absDividend = negDividend ? -dividendIn : dividendIn;
    assign absDivisor  = negDivisor ? -divisorIn : divisorIn;
    assign divByZero   = (divisorIn == '0);
    assign overflow    = i_wbTag[1] && (dividendIn == {1'b1, {(`ALU_WIDTH-1){1'b0}}})
                         && (divisorIn == '1);

    // No new cycle while the ack of the last one is out
    assign start    = i_wbCyc & i_wbStb & ~busy & ~o_wbAck;
    assign lastStep = (stepCount == `DIV_STEPS - 1);

    // First step runs on the load edge straight from the bus
    assign stepRem = busy ? remReg : '0;
    assign stepQuo = busy ? quoReg : absDividend;
    assign stepDiv = busy ? divisorReg : absDivisor;

    // Restoring step
    assign trial   = {stepRem, stepQuo[`ALU_WIDTH-1]} - {1'b0, stepDiv};
    assign fits    = ~trial[`ALU_WIDTH];
    assign nextRem = fits ? trial[`ALU_WIDTH-1:0]
                          : {stepRem[`ALU_WIDTH-2:0], stepQuo[`ALU_WIDTH-1]};
    assign nextQuo = {stepQuo[`ALU_WIDTH-2:0], fits};

    // Remainder follows the dividend sign
    assign finalQuo = negQuo ? -nextQuo : nextQuo;
    assign finalRem = negRem ? -nextRem : nextRem;

    always_ff @(posedge Clock) begin
        if (i_reset) begin
            busy      <= 1'b0;
            o_wbAck   <= 1'b0;
            stepCount <= '0;
        end else begin
            o_wbAck <= 1'b0;
            if (busy) begin
                stepCount <= stepCount + 1'b1;
                if (lastStep) begin
                    busy    <= 1'b0;
                    o_wbAck <= 1'b1;
                end
            end else if (start) begin
                if (divByZero || overflow) begin
                    o_wbAck <= 1'b1;  // Special cases answer at once
                end else begin
                    busy      <= 1'b1;
                    stepCount <= 1;
                end
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (busy || start) begin
            remReg <= nextRem;
            quoReg <= nextQuo;
        end
        if (start) begin
            divisorReg <= absDivisor;
            negQuo     <= negDividend ^ negDivisor;
            negRem     <= negDividend;
            remSel     <= i_wbTag[0];
        end
        if (start && divByZero) begin
            o_wbData <= i_wbTag[0] ? dividendIn : '1;
        end else if (start && overflow) begin
            o_wbData <= i_wbTag[0] ? '0 : dividendIn;
        end else if (busy && lastStep) begin
            o_wbData <= remSel ? finalRem : finalQuo;
        end
    end

endmodule

/* hw/intSqrt.sv */
`include "alu_config.svh"

module intSqrt (
    input  logic                   Clock,
    input  logic                   i_reset,
    input  logic                   i_start,
    input  logic [`ALU_WIDTH-1:0]  i_radicand,
    output logic                   o_done,
    output logic [`ALU_WIDTH-1:0]  o_root
);

    // Signed partial remainder with headroom for the shift
    localparam int RemWidth = `SQRT_STEPS + 4;

    logic                          busy;
    logic [$clog2(`SQRT_STEPS):0]  stepCount;
    logic                          lastStep;

    logic [RemWidth-1:0]           remReg;
    logic [`SQRT_STEPS-1:0]        rootReg;
    logic [`ALU_WIDTH-1:0]         radReg;

    logic [RemWidth-1:0]           stepRem;
    logic [`SQRT_STEPS-1:0]        stepRoot;
    logic [`ALU_WIDTH-1:0]         stepRad;
    logic [RemWidth-1:0]           shiftedRem;
    logic [RemWidth-1:0]           nextRem;
    logic [`SQRT_STEPS-1:0]        nextRoot;

    assign lastStep = (stepCount == `SQRT_STEPS - 1);

    // Load edge runs the first step from the input
    assign stepRem  = busy ? remReg : '0;
    assign stepRoot = busy ? rootReg : '0;
    assign stepRad  = busy ? radReg : i_radicand;

    assign shiftedRem = {stepRem[RemWidth-3:0], stepRad[`ALU_WIDTH-1:`ALU_WIDTH-2]};

    // Add back on a negative remainder instead of restoring
    always_comb begin
        if (stepRem[RemWidth-1]) begin
            nextRem = shiftedRem + RemWidth'({stepRoot, 2'b11});
        end else begin
            nextRem = shiftedRem - RemWidth'({stepRoot, 2'b01});
        end
    end

    assign nextRoot = {stepRoot[`SQRT_STEPS-2:0], ~nextRem[RemWidth-1]};

    always_ff @(posedge Clock) begin
        if (i_reset) begin
            busy      <= 1'b0;
            o_done    <= 1'b0;
            stepCount <= '0;
        end else begin
            o_done <= 1'b0;
            if (busy) begin
                stepCount <= stepCount + 1'b1;
                if (lastStep) begin
                    busy   <= 1'b0;
                    o_done <= 1'b1;
                end
            end else if (i_start) begin
                busy      <= 1'b1;
                stepCount <= 1;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (busy || i_start) begin
            remReg  <= nextRem;
            rootReg <= nextRoot;
            radReg  <= stepRad << 2;  // Next bit pair to the top
        end
        if (busy && lastStep) begin
            o_root <= `ALU_WIDTH'(nextRoot);
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build the ALU testbench with Verilator, run it and grade the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module aluTb -f compile.f -o aluSim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/aluSim 2>&1 | tee sim.log

# An aborted run has no pass line, so it counts as a failure too
! grep -q "Test failed" sim.log && grep -q "Test passed" sim.log \
    && { echo "Simulation result: PASS"; exit 0; } \
    || { echo "Simulation result: FAIL"; exit 1; }
